// ==== include/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define RESET_PC   32'h0000_0000
`define RAM_WORDS  1024

// cycle budget for each instruction slot in the testbench
`define MAX_CYCLES 4

`endif

// ==== hdl/cpu_types_pkg.sv ====
package cpu_types_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [4:0]  alu_op_t;   // {compare mode, alternate bit, funct3}
   typedef logic [1:0]  wd_sel_t;

   localparam wd_sel_t wd_alu  = 2'd0;
   localparam wd_sel_t wd_pc4  = 2'd1;
   localparam wd_sel_t wd_load = 2'd3;

   typedef enum logic [1:0] {
      step_fetch  = 2'd0,
      step_decode = 2'd1,
      step_mem    = 2'd2,
      step_write  = 2'd3
   } step_t;

   typedef struct packed {
      logic    pc_enable;
      logic    pc_load;
      logic    reg_re1;
      logic    reg_re2;
      logic    reg_we;
      logic    alu_sel1;      // PC instead of rs1
      logic    alu_sel2;      // immediate instead of rs2
      alu_op_t alu_op;
      logic    target_load;
      wd_sel_t wd_sel;
      logic    ram_addr_sel;  // ALU result instead of PC
      logic    inst_load;
      logic    inst_mux_sel;  // instruction register instead of ram_rdata
   } ctrl_t;

   typedef struct packed {
      logic [6:0] opcode;
      logic [2:0] funct3;
      logic       bit20;
      logic       bit30;
      logic       cmp_out;
   } decode_t;

endpackage

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

   typedef enum logic [6:0] {
      OP_IMM   = 7'b0010011,
      LUI      = 7'b0110111,
      AUIPC    = 7'b0010111,
      OP       = 7'b0110011,
      JAL      = 7'b1101111,
      JALR     = 7'b1100111,
      BRANCH   = 7'b1100011,
      LOAD     = 7'b0000011,
      STORE    = 7'b0100011,
      MISC_MEM = 7'b0001111,
      SYSTEM   = 7'b1110011
   } opcode_t;

   // arithmetic funct3, shared by OP and OP_IMM
   localparam logic [2:0] f3_add_sub = 3'b000;
   localparam logic [2:0] f3_sll     = 3'b001;
   localparam logic [2:0] f3_slt     = 3'b010;
   localparam logic [2:0] f3_sltu    = 3'b011;
   localparam logic [2:0] f3_xor     = 3'b100;
   localparam logic [2:0] f3_srl_sra = 3'b101;
   localparam logic [2:0] f3_or      = 3'b110;
   localparam logic [2:0] f3_and     = 3'b111;

   // branch funct3
   localparam logic [2:0] f3_beq  = 3'b000;
   localparam logic [2:0] f3_bne  = 3'b001;
   localparam logic [2:0] f3_blt  = 3'b100;
   localparam logic [2:0] f3_bge  = 3'b101;
   localparam logic [2:0] f3_bltu = 3'b110;
   localparam logic [2:0] f3_bgeu = 3'b111;

endpackage

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu (
   input  cpu_types_pkg::word_t   a,
   input  cpu_types_pkg::word_t   b,
   input  cpu_types_pkg::alu_op_t op,
   output cpu_types_pkg::word_t   result,
   output logic                   cmp_out
);

   logic       alt;
   logic [2:0] funct3;
   logic       cond;

   assign alt    = op[3];
   assign funct3 = op[2:0];

   always_comb begin
      case (funct3)
         isa_pkg::f3_add_sub: result = alt ? a - b : a + b;
         isa_pkg::f3_sll:     result = a << b[4:0];
         isa_pkg::f3_slt:     result = {31'b0, $signed(a) < $signed(b)};
         isa_pkg::f3_sltu:    result = {31'b0, a < b};
         isa_pkg::f3_xor:     result = a ^ b;
         isa_pkg::f3_srl_sra: begin
            if (alt) begin
               result = $signed(a) >>> b[4:0];
            end else begin
               result = a >> b[4:0];
            end
         end
         isa_pkg::f3_or:      result = a | b;
         default:             result = a & b;
      endcase
   end

   always_comb begin
      case (funct3)
         isa_pkg::f3_beq:  cond = a == b;
         isa_pkg::f3_bne:  cond = a != b;
         isa_pkg::f3_blt:  cond = $signed(a) < $signed(b);
         isa_pkg::f3_bge:  cond = $signed(a) >= $signed(b);
         isa_pkg::f3_bltu: cond = a < b;
         isa_pkg::f3_bgeu: cond = a >= b;
         default:          cond = 1'b0;
      endcase
   end

   assign cmp_out = op[4] && cond;  // only meaningful in compare mode

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
   input  logic                     clk,
   input  logic                     re1,
   input  logic                     re2,
   input  logic                     we,
   input  cpu_types_pkg::reg_addr_t ra1,
   input  cpu_types_pkg::reg_addr_t ra2,
   input  cpu_types_pkg::reg_addr_t wa,
   input  cpu_types_pkg::word_t     wd,
   output cpu_types_pkg::word_t     rd1,
   output cpu_types_pkg::word_t     rd2
);

   cpu_types_pkg::word_t regs [32];

   always_ff @(posedge clk) begin
      if (we && wa != 5'd0) begin
         regs[wa] <= wd;
      end
      if (re1) begin
         rd1 <= (ra1 == 5'd0) ? '0 : regs[ra1];
      end
      if (re2) begin
         rd2 <= (ra2 == 5'd0) ? '0 : regs[ra2];
      end
   end

endmodule

// ==== hdl/control.sv ====
`timescale 1ns/1ps

module control (
   input  logic                   clk,
   input  logic                   reset,
   input  cpu_types_pkg::decode_t dec,
   output cpu_types_pkg::ctrl_t   ctrl,
   output logic                   ram_re,
   output logic                   ram_we,
   output logic                   halt,
   output cpu_types_pkg::step_t   step
);

   logic is_lui, is_auipc, is_op, is_op_imm, is_jal, is_jalr;
   logic is_branch, is_load, is_store, is_system;
   logic fetch, decode, mem, write;

   always_ff @(posedge clk) begin
      if (reset) begin
         step <= cpu_types_pkg::step_fetch;
      end else begin
         step <= cpu_types_pkg::step_t'(step + 2'd1);  // wraps after write-back
      end
   end

   assign fetch  = step == cpu_types_pkg::step_fetch;
   assign decode = step == cpu_types_pkg::step_decode;
   assign mem    = step == cpu_types_pkg::step_mem;
   assign write  = step == cpu_types_pkg::step_write;

   assign is_lui    = dec.opcode == isa_pkg::LUI;
   assign is_auipc  = dec.opcode == isa_pkg::AUIPC;
   assign is_op     = dec.opcode == isa_pkg::OP;
   assign is_op_imm = dec.opcode == isa_pkg::OP_IMM;
   assign is_jal    = dec.opcode == isa_pkg::JAL;
   assign is_jalr   = dec.opcode == isa_pkg::JALR;
   assign is_branch = dec.opcode == isa_pkg::BRANCH;
   assign is_load   = dec.opcode == isa_pkg::LOAD;
   assign is_store  = dec.opcode == isa_pkg::STORE;
   assign is_system = dec.opcode == isa_pkg::SYSTEM;

   assign halt   = is_system && dec.bit20;  // ebreak
   assign ram_re = fetch || (mem && is_load);
   assign ram_we = mem && is_store;

   always_comb begin
      ctrl = '0;

      ctrl.pc_enable = write && !halt;
      ctrl.pc_load   = write && ((is_branch && dec.cmp_out) || is_jal || is_jalr);

      ctrl.reg_re1 = decode;
      ctrl.reg_re2 = decode;
      ctrl.reg_we  = write && (is_op || is_op_imm || is_lui || is_auipc ||
                               is_jal || is_jalr || is_load);

      // decode computes PC plus immediate for the branch and jump target
      if (decode || (write && is_auipc)) begin
         ctrl.alu_sel1 = 1'b1;
         ctrl.alu_sel2 = 1'b1;
      end else if ((write && (is_op_imm || is_lui)) ||
                   (mem && (is_load || is_store || is_jalr))) begin
         ctrl.alu_sel2 = 1'b1;
      end

      if (write && is_op) begin
         ctrl.alu_op = {1'b0, dec.bit30, dec.funct3};
      end else if (write && is_op_imm) begin
         // bit 30 is immediate data except for the right shifts
         ctrl.alu_op = {1'b0, dec.bit30 && dec.funct3 == isa_pkg::f3_srl_sra, dec.funct3};
      end else if (write && is_branch) begin
         ctrl.alu_op = {1'b1, 1'b0, dec.funct3};
      end

      ctrl.target_load = decode || (mem && is_jalr);

      if (is_jal || is_jalr) begin
         ctrl.wd_sel = cpu_types_pkg::wd_pc4;
      end else if (is_load) begin
         ctrl.wd_sel = cpu_types_pkg::wd_load;
      end else begin
         ctrl.wd_sel = cpu_types_pkg::wd_alu;
      end

      ctrl.ram_addr_sel = mem;
      ctrl.inst_load    = decode;
      ctrl.inst_mux_sel = !decode;  // fetch keeps the last instruction so halt holds
   end

endmodule

// ==== hdl/datapath.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module datapath (
   input  logic                   clk,
   input  logic                   reset,
   input  cpu_types_pkg::ctrl_t   ctrl,
   input  cpu_types_pkg::word_t   ram_rdata,
   output cpu_types_pkg::decode_t dec,
   output cpu_types_pkg::word_t   ram_addr,
   output cpu_types_pkg::word_t   ram_wdata
);

   // byte address bits that reach the memory
   localparam int unsigned addr_bits = $clog2(`RAM_WORDS) + 2;

   cpu_types_pkg::word_t      pc, pc_plus4, target, inst_reg, inst;
   cpu_types_pkg::word_t      imm, rd1, rd2, alu_a, alu_b, alu_result, wd, addr;
   cpu_types_pkg::reg_addr_t  ra1;
   logic                      cmp_out;

   assign pc_plus4 = pc + 32'd4;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc       <= `RESET_PC;
         inst_reg <= 32'h0000_0013;  // addi x0, x0, 0 until the first fetch lands
      end else begin
         if (ctrl.pc_enable) begin
            pc <= ctrl.pc_load ? target : pc_plus4;
         end
         if (ctrl.inst_load) begin
            inst_reg <= ram_rdata;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ctrl.target_load) begin
         target <= {alu_result[31:1], 1'b0};
      end
   end

   assign inst = ctrl.inst_mux_sel ? inst_reg : ram_rdata;

   always_comb begin
      case (inst[6:0])
         isa_pkg::STORE:             imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
         isa_pkg::BRANCH:            imm = {{19{inst[31]}}, inst[31], inst[7],
                                            inst[30:25], inst[11:8], 1'b0};
         isa_pkg::LUI, isa_pkg::AUIPC: imm = {inst[31:12], 12'b0};
         isa_pkg::JAL:               imm = {{11{inst[31]}}, inst[31], inst[19:12],
                                            inst[20], inst[30:21], 1'b0};
         default:                    imm = {{20{inst[31]}}, inst[31:20]};
      endcase
   end

   // lui adds its immediate to x0
   assign ra1 = (inst[6:0] == isa_pkg::LUI) ? 5'd0 : inst[19:15];

   reg_file u_reg_file (
      .clk (clk),
      .re1 (ctrl.reg_re1),
      .re2 (ctrl.reg_re2),
      .we  (ctrl.reg_we),
      .ra1 (ra1),
      .ra2 (inst[24:20]),
      .wa  (inst[11:7]),
      .wd  (wd),
      .rd1 (rd1),
      .rd2 (rd2)
   );

   assign alu_a = ctrl.alu_sel1 ? pc : rd1;
   assign alu_b = ctrl.alu_sel2 ? imm : rd2;

   alu u_alu (
      .a       (alu_a),
      .b       (alu_b),
      .op      (ctrl.alu_op),
      .result  (alu_result),
      .cmp_out (cmp_out)
   );

   always_comb begin
      case (ctrl.wd_sel)
         cpu_types_pkg::wd_pc4:  wd = pc_plus4;
         cpu_types_pkg::wd_load: wd = ram_rdata;
         default:                wd = alu_result;
      endcase
   end

   assign addr      = ctrl.ram_addr_sel ? alu_result : pc;
   assign ram_addr  = {{(32 - addr_bits){1'b0}}, addr[addr_bits-1:0]};
   assign ram_wdata = rd2;

   assign dec.opcode  = inst[6:0];
   assign dec.funct3  = inst[14:12];
   assign dec.bit20   = inst[20];
   assign dec.bit30   = inst[30];
   assign dec.cmp_out = cmp_out;

endmodule

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
   input  logic                 clk,
   input  logic                 reset,
   input  cpu_types_pkg::word_t ram_rdata,
   output cpu_types_pkg::word_t ram_addr,
   output cpu_types_pkg::word_t ram_wdata,
   output logic                 ram_re,
   output logic                 ram_we,
   output logic                 halt
);

   cpu_types_pkg::ctrl_t   ctrl;
   cpu_types_pkg::decode_t dec;

   control u_control (
      .clk    (clk),
      .reset  (reset),
      .dec    (dec),
      .ctrl   (ctrl),
      .ram_re (ram_re),
      .ram_we (ram_we),
      .halt   (halt),
      .step   ()
   );

   datapath u_datapath (
      .clk       (clk),
      .reset     (reset),
      .ctrl      (ctrl),
      .ram_rdata (ram_rdata),
      .dec       (dec),
      .ram_addr  (ram_addr),
      .ram_wdata (ram_wdata)
   );

endmodule

// ==== testbench/cpu_props.sv ====
`timescale 1ns/1ps

module cpu_props (
   input logic                 clk,
   input logic                 reset,
   input cpu_types_pkg::step_t step,
   input cpu_types_pkg::ctrl_t ctrl,
   input logic                 ram_re,
   input logic                 ram_we,
   input logic                 halt
);

   step_advances: assert property (@(posedge clk) disable iff (reset)
      !$past(reset) |-> step == cpu_types_pkg::step_t'($past(step) + 2'd1))
      else $error("step did not advance by one");

   bus_exclusive: assert property (@(posedge clk) disable iff (reset) !(ram_we && ram_re))
      else $error("ram_we and ram_re high together");

   halt_freezes_pc: assert property (@(posedge clk) disable iff (reset)
      !(halt && ctrl.pc_enable))
      else $error("pc_enable while halted");

   // register writes belong to write-back only
   write_in_step: assert property (@(posedge clk) disable iff (reset)
      ctrl.reg_we |-> step == cpu_types_pkg::step_write)
      else $error("reg_we outside write-back");

endmodule

bind control cpu_props u_props (
   .clk    (clk),
   .reset  (reset),
   .step   (step),
   .ctrl   (ctrl),
   .ram_re (ram_re),
   .ram_we (ram_we),
   .halt   (halt)
);

// ==== testbench/tb_cpu.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tb_cpu;

   localparam int idx_bits = $clog2(`RAM_WORDS);
   localparam int hdr      = 1024;  // word index of the expectation section in the data file

   logic                 clk;
   logic                 reset;
   cpu_types_pkg::word_t ram_rdata;
   cpu_types_pkg::word_t ram_addr;
   cpu_types_pkg::word_t ram_wdata;
   logic                 ram_re;
   logic                 ram_we;
   logic                 halt;

   cpu_types_pkg::word_t tests [2048];
   cpu_types_pkg::word_t ram [`RAM_WORDS];
   cpu_types_pkg::word_t exp_addr [$];
   cpu_types_pkg::word_t exp_data [$];
   cpu_types_pkg::word_t halt_pc;
   cpu_types_pkg::word_t rd_data;
   logic                 rd_pending;

   int cycles;
   int limit;
   int store_idx;
   int addr_errors;
   int data_errors;
   int halt_errors;
   int other_errors;

   cpu_top u_dut (
      .clk       (clk),
      .reset     (reset),
      .ram_rdata (ram_rdata),
      .ram_addr  (ram_addr),
      .ram_wdata (ram_wdata),
      .ram_re    (ram_re),
      .ram_we    (ram_we),
      .halt      (halt)
   );

   always #5 clk = ~clk;

   task automatic check_store_addr(input int idx, input cpu_types_pkg::word_t got,
                                   input cpu_types_pkg::word_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED ram_addr store %0d: got %h expected %h", idx, got, exp);
         addr_errors++;
      end
   endtask

   task automatic check_store_data(input int idx, input cpu_types_pkg::word_t got,
                                   input cpu_types_pkg::word_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED ram_wdata store %0d: got %h expected %h", idx, got, exp);
         data_errors++;
      end
   endtask

   task automatic check_halt_pc(input cpu_types_pkg::word_t got,
                                input cpu_types_pkg::word_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED ram_addr at halted fetch: got %h expected %h", got, exp);
         halt_errors++;
      end
   endtask

   // the memory has a registered read and its data shows up one cycle after ram_re
   always @(negedge clk) begin
      if (rd_pending) begin
         ram_rdata <= rd_data;
      end
      rd_pending = ram_re;
      if (ram_re) begin
         rd_data = ram[ram_addr[idx_bits+1:2]];
      end
      if (ram_we) begin
         ram[ram_addr[idx_bits+1:2]] = ram_wdata;
      end
   end

   // every store the core makes has to be the next one on the expected list
   always @(negedge clk) begin
      if (!reset && ram_we) begin
         if (store_idx >= exp_addr.size()) begin
            $display("store beyond the expected list, at address %h", ram_addr);
            other_errors++;
         end else begin
            check_store_addr(store_idx, ram_addr, exp_addr[store_idx]);
            check_store_data(store_idx, ram_wdata, exp_data[store_idx]);
         end
         store_idx++;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > limit) begin
         $display("timeout: the core did not reach its halt within %0d cycles", limit);
         $display("test failed");
         $finish;
      end
   end

   initial begin
      int halted_fetches;
      int n_stores;

      clk          = 1'b0;
      reset        = 1'b1;
      ram_rdata    <= '0;
      rd_data      = '0;
      rd_pending   = 1'b0;
      cycles       = 0;
      store_idx    = 0;
      addr_errors  = 0;
      data_errors  = 0;
      halt_errors  = 0;
      other_errors = 0;

      $readmemh("testbench/cpu_tests.txt", tests);
      for (int i = 0; i < `RAM_WORDS; i++) begin
         ram[i] = 32'hdead_0000 ^ cpu_types_pkg::word_t'(i);
      end
      for (int i = 0; i < int'(tests[hdr]); i++) begin
         ram[i] = tests[i];
      end
      limit    = int'(tests[hdr+1]) * 4 * `MAX_CYCLES;
      n_stores = int'(tests[hdr+2]);
      halt_pc  = tests[hdr+3];
      for (int k = 0; k < n_stores; k++) begin
         exp_addr.push_back(tests[hdr+4+2*k]);
         exp_data.push_back(tests[hdr+5+2*k]);
      end

      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // a halted core keeps refetching the ebreak
      halted_fetches = 0;
      while (halted_fetches < 3) begin
         @(negedge clk);
         if (halt && ram_re) begin
            check_halt_pc(ram_addr, halt_pc);
            halted_fetches++;
         end
      end

      if (store_idx != n_stores) begin
         $display("expected %0d stores but the core made %0d", n_stores, store_idx);
         other_errors++;
      end

      $display("store address errors %0d, store data errors %0d, halt errors %0d, other %0d",
               addr_errors, data_errors, halt_errors, other_errors);
      if (addr_errors + data_errors + halt_errors + other_errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// ==== testbench/cpu_tests.txt ====
// from word 0: program words. from word 0x400: program length, executed instructions,
// store count, halt pc, then one store address and its data per line
@000
00500093 FFD00113 402081B3 40115233  // addi x1 5, addi x2 -3, sub, sra
001122B3 40115313 40008393           // slt, srai, addi with imm bit 10
20302023 20402223 20502423 20602623  // sw x3..x6
20702823                             // sw x7
12345437 00001497 20802A23 20902C23  // lui, auipc, sw x8, sw x9
00108463 00148493 00208463 00140413  // beq taken, beq not taken
00209463 00248493 00109463 00240413  // bne taken, bne not taken
00114463 00448493 0020C463 00440413  // blt taken, blt not taken
0020D463 00848493 00115463 00840413  // bge taken, bge not taken
0020E463 01048493 00116463 01040413  // bltu taken, bltu not taken
00117463 02048493 0020F463 02040413  // bgeu taken, bgeu not taken
20802E23 22902023                    // sw x8, sw x9
0080066F 04048493                    // jal x12 over a bad addi
0B4186E7 08048493 10048493           // jalr x13 via x3 over two bad addi
22C02223 22D02423 22902623           // sw x12, sw x13, sw x9
20402703 001707B3 22F02823           // lw back, add, sw x15
00108013 22002A23                    // write to x0, sw x0
00100073                             // ebreak
@400
00000038 0000002F 0000000E 000000DC
00000200 00000008
00000204 FFFFFFFF
00000208 00000001
0000020C FFFFFFFE
00000210 00000405
00000214 12345000
00000218 00001034
0000021C 1234503F
00000220 00001034
00000224 000000AC
00000228 000000B4
0000022C 00001034
00000230 00000004
00000234 00000000

// ==== vlog.f ====
+incdir+include
hdl/cpu_types_pkg.sv
hdl/isa_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/control.sv
hdl/datapath.sv
hdl/cpu_top.sv
testbench/cpu_props.sv
testbench/tb_cpu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_cpu

output=$(./obj_dir/Vtb_cpu) || true
echo "$output"

if grep -qx "test passed" <<< "$output"; then
   exit 0
else
   exit 1
fi
